/* source/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// pc value carried by an empty slot in the pipe
`define CORE_BUBBLE_PC 32'hffff_ffff

// reaching this pc ends the program
`define CORE_EXIT_PC 32'hffff_ff00

// x2 (sp) starts at the top of the data ram
`define CORE_SP_RESET 32'h0000_2000

// x1 and x3..x31 come out of reset at this value
`define CORE_REG_RESET 32'hffff_ffff

`endif

/* source/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    // writeback source, 4 bit code from decode
    typedef enum logic [3:0] {
        WB_ALU   = 4'd0,
        WB_MEMB  = 4'd1,  // lb
        WB_MEMBU = 4'd2,  // lbu
        WB_MEMH  = 4'd3,  // lh
        WB_MEMHU = 4'd4,  // lhu
        WB_MEMW  = 4'd5,  // lw
        WB_PC    = 4'd6,  // jal/jalr link
        WB_CSR   = 4'd7
    } wb_sel_e;

    // one word from data memory, seen as byte lanes or halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

endpackage

`default_nettype wire

/* source/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    typedef enum logic [2:0] {
        CSR_X     = 3'd0,  // no csr access
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5,
        CSR_SRET  = 3'd6
    } csr_cmd_e;

endpackage

`default_nettype wire

/* source/load_result_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module load_result_mux (
    input  wire wb_pkg::wb_sel_e   wb_sel_i,
    input  wire wb_pkg::mem_word_u mem_rdata_i,
    input  wire logic [31:0]       pc_plus4_i,
    input  wire logic [31:0]       csr_rdata_i,
    input  wire logic [31:0]       alu_out_i,
    output logic [31:0]            wb_data_o
);

    import wb_pkg::*;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] ld_byte_s;
    logic [31:0] ld_byte_u;
    logic [31:0] ld_half_s;
    logic [31:0] ld_half_u;

    assign ld_byte = mem_rdata_i.bytes[0];   // aligned load, lane 0
    assign ld_half = mem_rdata_i.halves[0];

    assign ld_byte_s = {{24{ld_byte[7]}}, ld_byte};
    assign ld_byte_u = {24'd0, ld_byte};
    assign ld_half_s = {{16{ld_half[15]}}, ld_half};
    assign ld_half_u = {16'd0, ld_half};

    always_comb begin
        case (wb_sel_i)
            WB_MEMB:  wb_data_o = ld_byte_s;
            WB_MEMBU: wb_data_o = ld_byte_u;
            WB_MEMH:  wb_data_o = ld_half_s;
            WB_MEMHU: wb_data_o = ld_half_u;
            WB_MEMW:  wb_data_o = mem_rdata_i;
            WB_PC:    wb_data_o = pc_plus4_i;
            WB_CSR:   wb_data_o = csr_rdata_i;
            default:  wb_data_o = alu_out_i;  // WB_ALU and unused codes
        endcase
    end

    // decode must never hand over an undriven select
    always_comb begin
        wb_sel_known: assert final (!$isunknown(wb_sel_i))
            else $error("wb_sel_i is unknown");
    end

endmodule

`default_nettype wire

/* source/pc_redirect.sv */
`timescale 1ns/10ps
`default_nettype none

module pc_redirect (
    input  wire logic [31:0]      reg_pc_i,
    input  wire logic             br_flg_i,
    input  wire logic [31:0]      br_target_i,
    input  wire logic             jmp_flg_i,
    input  wire logic [31:0]      alu_out_i,
    input  wire csr_pkg::csr_cmd_e csr_cmd_i,
    input  wire logic [31:0]      trap_vector_i,
    output logic [31:0]           pc_plus4_o,
    output logic [31:0]           next_pc_o,
    output logic                  redirect_o
);

    import csr_pkg::*;

    logic is_trap;

    assign pc_plus4_o = reg_pc_i + 32'd4;

    assign is_trap = (csr_cmd_i == CSR_ECALL) ||
                     (csr_cmd_i == CSR_MRET)  ||
                     (csr_cmd_i == CSR_SRET);

    always_comb begin
        if (br_flg_i) begin
            next_pc_o = br_target_i;
        end else if (jmp_flg_i) begin
            next_pc_o = alu_out_i;      // jal/jalr target from the alu
        end else if (is_trap) begin
            next_pc_o = trap_vector_i;
        end else begin
            next_pc_o = pc_plus4_o;
        end
    end

    assign redirect_o = br_flg_i | jmp_flg_i | is_trap;  // flushes the front end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module reg_file (
    input  wire logic        clk,
    input  wire logic        arst_n_i,
    input  wire logic        we_i,
    input  wire logic [4:0]  waddr_i,
    input  wire logic [31:0] wdata_i,
    input  wire logic [4:0]  raddr_a_i,
    input  wire logic [4:0]  raddr_b_i,
    output logic [31:0]      rdata_a_o,
    output logic [31:0]      rdata_b_o
);

    logic [31:0] regs [1:31];  // x0 is not stored

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                if (i == 2) begin
                    regs[i] <= `CORE_SP_RESET;
                end else begin
                    regs[i] <= `CORE_REG_RESET;
                end
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // new data shows after the edge since there is no write bypass
    assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'd0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'd0 : regs[raddr_b_i];

    // written data reads back on the next cycle
    wr_read_a: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (we_i && (waddr_i != 5'd0)) |=>
            ((raddr_a_i != $past(waddr_i)) || (rdata_a_o == $past(wdata_i)))
    ) else $error("port a missed the last write");

    wr_read_b: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (we_i && (waddr_i != 5'd0)) |=>
            ((raddr_b_i != $past(waddr_i)) || (rdata_b_o == $past(wdata_i)))
    ) else $error("port b missed the last write");

endmodule

`default_nettype wire

/* source/writeback_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module writeback_stage (
    input  wire logic              clk,
    input  wire logic              arst_n_i,

    input  wire logic [31:0]       reg_pc_i,
    input  wire wb_pkg::wb_sel_e   wb_sel_i,
    input  wire logic [4:0]        wb_addr_i,
    input  wire logic              rf_wen_i,
    input  wire csr_pkg::csr_cmd_e csr_cmd_i,
    input  wire logic              br_flg_i,
    input  wire logic              jmp_flg_i,
    input  wire logic [31:0]       br_target_i,
    input  wire logic [31:0]       alu_out_i,
    input  wire logic [31:0]       csr_rdata_i,
    input  wire logic [31:0]       mem_rdata_i,
    input  wire logic [31:0]       trap_vector_i,
    input  wire logic [4:0]        rs1_addr_i,
    input  wire logic [4:0]        rs2_addr_i,

    output logic [31:0]            next_pc_o,
    output logic                   redirect_o,
    output logic [31:0]            rs1_data_o,
    output logic [31:0]            rs2_data_o,
    output logic [31:0]            retired_o,
    output logic                   exit_o
);

    logic [31:0] pc_plus4;
    logic [31:0] wb_data;
    logic [31:0] retired_q;

    pc_redirect i_pc_redirect (
        .reg_pc_i      (reg_pc_i),
        .br_flg_i      (br_flg_i),
        .br_target_i   (br_target_i),
        .jmp_flg_i     (jmp_flg_i),
        .alu_out_i     (alu_out_i),
        .csr_cmd_i     (csr_cmd_i),
        .trap_vector_i (trap_vector_i),
        .pc_plus4_o    (pc_plus4),
        .next_pc_o     (next_pc_o),
        .redirect_o    (redirect_o)
    );

    load_result_mux i_load_result_mux (
        .wb_sel_i    (wb_sel_i),
        .mem_rdata_i (mem_rdata_i),
        .pc_plus4_i  (pc_plus4),     // link address for jal/jalr
        .csr_rdata_i (csr_rdata_i),
        .alu_out_i   (alu_out_i),
        .wb_data_o   (wb_data)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .we_i      (rf_wen_i),
        .waddr_i   (wb_addr_i),
        .wdata_i   (wb_data),
        .raddr_a_i (rs1_addr_i),
        .raddr_b_i (rs2_addr_i),
        .rdata_a_o (rs1_data_o),
        .rdata_b_o (rs2_data_o)
    );

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retired_q <= 32'd0;
        end else if (reg_pc_i != `CORE_BUBBLE_PC) begin
            retired_q <= retired_q + 32'd1;  // bubbles do not retire
        end
    end

    assign retired_o = retired_q;
    assign exit_o    = (reg_pc_i == `CORE_EXIT_PC);

endmodule

`default_nettype wire

/* testbench/tb_writeback_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module tb_writeback_stage;

    import wb_pkg::*;
    import csr_pkg::*;

    localparam int unsigned EDGE_POLL_LIMIT = 150;  // 1 ns polls over a 100 ns clock period
    localparam int unsigned RANDOM_CYCLES   = 200;

    logic        clk;
    logic        arst_n_i;
    logic [31:0] reg_pc_i;
    wb_sel_e     wb_sel_i;
    logic [4:0]  wb_addr_i;
    logic        rf_wen_i;
    csr_cmd_e    csr_cmd_i;
    logic        br_flg_i;
    logic        jmp_flg_i;
    logic [31:0] br_target_i;
    logic [31:0] alu_out_i;
    logic [31:0] csr_rdata_i;
    logic [31:0] mem_rdata_i;
    logic [31:0] trap_vector_i;
    logic [4:0]  rs1_addr_i;
    logic [4:0]  rs2_addr_i;
    logic [31:0] next_pc_o;
    logic        redirect_o;
    logic [31:0] rs1_data_o;
    logic [31:0] rs2_data_o;
    logic [31:0] retired_o;
    logic        exit_o;

    logic [31:0] lfsr_state;
    logic [31:0] shadow_regs [32];
    logic [31:0] shadow_retired;

    writeback_stage i_dut (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .reg_pc_i      (reg_pc_i),
        .wb_sel_i      (wb_sel_i),
        .wb_addr_i     (wb_addr_i),
        .rf_wen_i      (rf_wen_i),
        .csr_cmd_i     (csr_cmd_i),
        .br_flg_i      (br_flg_i),
        .jmp_flg_i     (jmp_flg_i),
        .br_target_i   (br_target_i),
        .alu_out_i     (alu_out_i),
        .csr_rdata_i   (csr_rdata_i),
        .mem_rdata_i   (mem_rdata_i),
        .trap_vector_i (trap_vector_i),
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .next_pc_o     (next_pc_o),
        .redirect_o    (redirect_o),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o),
        .retired_o     (retired_o),
        .exit_o        (exit_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50;
            clk = ~clk;
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    // waits one clock period and returns just after a falling edge
    task automatic wait_falling_edge();
        int unsigned polls;
        polls = 0;
        while (clk !== 1'b1 && polls < EDGE_POLL_LIMIT) begin
            #1;
            polls++;
        end
        while (clk !== 1'b0 && polls < EDGE_POLL_LIMIT) begin
            #1;
            polls++;
        end
        if (polls >= EDGE_POLL_LIMIT) begin
            stop_on_error("clock did not reach a falling edge in time, the clock seems stuck");
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned nbits);
        logic [31:0] val;
        val = 32'd0;
        for (int unsigned k = 0; k < nbits; k++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [1:0] kind;
        kind = 2'(rand_bits(2));
        case (kind)
            2'd0:    return `CORE_BUBBLE_PC;
            2'd1:    return `CORE_EXIT_PC;
            default: return rand_bits(30) << 2;
        endcase
    endfunction

    function automatic logic [31:0] ref_wb_data(input logic [3:0] sel, input logic [31:0] mem,
                                                input logic [31:0] pc, input logic [31:0] csr,
                                                input logic [31:0] alu);
        case (sel)
            WB_MEMB:  return {{24{mem[7]}}, mem[7:0]};
            WB_MEMBU: return {24'd0, mem[7:0]};
            WB_MEMH:  return {{16{mem[15]}}, mem[15:0]};
            WB_MEMHU: return {16'd0, mem[15:0]};
            WB_MEMW:  return mem;
            WB_PC:    return pc + 32'd4;
            WB_CSR:   return csr;
            default:  return alu;
        endcase
    endfunction

    function automatic logic is_trap_cmd(input logic [2:0] cmd);
        return (cmd == CSR_ECALL) || (cmd == CSR_MRET) || (cmd == CSR_SRET);
    endfunction

    function automatic logic [31:0] ref_next_pc(input logic br, input logic jmp,
                                                input logic [2:0] cmd, input logic [31:0] pc,
                                                input logic [31:0] br_target,
                                                input logic [31:0] alu,
                                                input logic [31:0] trap_vec);
        if (br) begin
            return br_target;
        end else if (jmp) begin
            return alu;
        end else if (is_trap_cmd(cmd)) begin
            return trap_vec;
        end
        return pc + 32'd4;
    endfunction

    // no branch, no jump, no trap, no write
    task automatic drive_quiet();
        br_flg_i      = 1'b0;
        jmp_flg_i     = 1'b0;
        csr_cmd_i     = CSR_X;
        rf_wen_i      = 1'b0;
        br_target_i   = rand_bits(32);
        alu_out_i     = rand_bits(32);
        csr_rdata_i   = rand_bits(32);
        trap_vector_i = rand_bits(32);
        mem_rdata_i   = rand_bits(32);
    endtask

    task automatic drive_random_all();
        drive_quiet();
        reg_pc_i   = rand_pc();
        wb_sel_i   = wb_sel_e'(4'(rand_bits(4)));
        wb_addr_i  = 5'(rand_bits(5));
        rf_wen_i   = 1'(rand_bits(1));
        csr_cmd_i  = csr_cmd_e'(3'(rand_bits(3)));
        br_flg_i   = 1'(rand_bits(1));
        jmp_flg_i  = 1'(rand_bits(1));
        rs1_addr_i = 5'(rand_bits(5));
        rs2_addr_i = 5'(rand_bits(5));
    endtask

    // checks the comb outputs, then clocks and checks the state
    task automatic run_cycle(input string name);
        logic [31:0] exp_wb;
        #1;
        check_value({name, " next_pc"}, ref_next_pc(br_flg_i, jmp_flg_i, csr_cmd_i, reg_pc_i,
                    br_target_i, alu_out_i, trap_vector_i), next_pc_o);
        check_value({name, " redirect"},
                    32'(br_flg_i | jmp_flg_i | is_trap_cmd(csr_cmd_i)), 32'(redirect_o));
        check_value({name, " exit"}, 32'(reg_pc_i == `CORE_EXIT_PC), 32'(exit_o));
        exp_wb = ref_wb_data(wb_sel_i, mem_rdata_i, reg_pc_i, csr_rdata_i, alu_out_i);
        wait_falling_edge();
        if (rf_wen_i && (wb_addr_i != 5'd0)) begin
            shadow_regs[wb_addr_i] = exp_wb;
        end
        if (reg_pc_i != `CORE_BUBBLE_PC) begin
            shadow_retired = shadow_retired + 32'd1;
        end
        check_value({name, " retired"}, shadow_retired, retired_o);
        check_value({name, " rs1"}, shadow_regs[rs1_addr_i], rs1_data_o);
        check_value({name, " rs2"}, shadow_regs[rs2_addr_i], rs2_data_o);
    endtask

    task automatic check_all_regs(input string name);
        reg_pc_i = `CORE_BUBBLE_PC;  // idle cycle so nothing retires
        rf_wen_i = 1'b0;
        for (int i = 0; i < 32; i++) begin
            rs1_addr_i = 5'(i);
            rs2_addr_i = 5'(31 - i);
            #1;
            check_value($sformatf("%s rs1 x%0d", name, i), shadow_regs[i], rs1_data_o);
            check_value($sformatf("%s rs2 x%0d", name, 31 - i), shadow_regs[31 - i], rs2_data_o);
        end
        wait_falling_edge();
    endtask

    task automatic load_case(input wb_sel_e sel, input string name);
        for (int k = 0; k < 4; k++) begin
            drive_quiet();
            mem_rdata_i[7]  = k[0];  // both signs of the loaded byte and halfword
            mem_rdata_i[15] = k[0];
            reg_pc_i   = rand_bits(30) << 2;
            wb_sel_i   = sel;
            wb_addr_i  = 5'(rand_bits(5));
            if (wb_addr_i == 5'd0) begin
                wb_addr_i = 5'd1;  // x0 would hide the loaded value
            end
            rf_wen_i   = 1'b1;
            rs1_addr_i = wb_addr_i;  // read back what was just written
            rs2_addr_i = 5'(rand_bits(5));
            run_cycle(name);
        end
    endtask

    task automatic source_case(input logic [3:0] sel_code, input logic [4:0] addr,
                               input logic wen, input string name);
        drive_quiet();
        reg_pc_i   = rand_bits(30) << 2;
        wb_sel_i   = wb_sel_e'(sel_code);
        wb_addr_i  = addr;
        rf_wen_i   = wen;
        rs1_addr_i = addr;
        rs2_addr_i = 5'(rand_bits(5));
        run_cycle(name);
    endtask

    initial begin
        lfsr_state    = 32'd80;
        arst_n_i      = 1'b0;
        reg_pc_i      = `CORE_BUBBLE_PC;
        wb_sel_i      = WB_ALU;
        wb_addr_i     = 5'd0;
        rf_wen_i      = 1'b0;
        csr_cmd_i     = CSR_X;
        br_flg_i      = 1'b0;
        jmp_flg_i     = 1'b0;
        br_target_i   = 32'd0;
        alu_out_i     = 32'd0;
        csr_rdata_i   = 32'd0;
        mem_rdata_i   = 32'd0;
        trap_vector_i = 32'd0;
        rs1_addr_i    = 5'd0;
        rs2_addr_i    = 5'd0;

        for (int i = 0; i < 32; i++) begin
            shadow_regs[i] = `CORE_REG_RESET;
        end
        shadow_regs[0] = 32'd0;
        shadow_regs[2] = `CORE_SP_RESET;
        shadow_retired = 32'd0;

        repeat (3) begin
            wait_falling_edge();
        end
        arst_n_i = 1'b1;

        check_value("reset retired", 32'd0, retired_o);
        check_value("reset exit", 32'd0, 32'(exit_o));
        check_all_regs("reset");

        load_case(WB_MEMB, "load lb");
        load_case(WB_MEMBU, "load lbu");
        load_case(WB_MEMH, "load lh");
        load_case(WB_MEMHU, "load lhu");
        load_case(WB_MEMW, "load lw");

        source_case(WB_PC, 5'd5, 1'b1, "wb pc");
        source_case(WB_CSR, 5'd6, 1'b1, "wb csr");
        source_case(WB_ALU, 5'd7, 1'b1, "wb alu");
        source_case(4'd9, 5'd8, 1'b1, "wb unknown 9");
        source_case(4'd15, 5'd9, 1'b1, "wb unknown 15");
        source_case(WB_ALU, 5'd0, 1'b1, "x0 write");
        source_case(WB_CSR, 5'd10, 1'b0, "write disabled");
        check_all_regs("after sources");

        repeat (40) begin
            drive_quiet();
            reg_pc_i   = rand_bits(30) << 2;
            br_flg_i   = 1'(rand_bits(1));
            jmp_flg_i  = 1'(rand_bits(1));
            csr_cmd_i  = csr_cmd_e'(3'(rand_bits(3)));
            rs1_addr_i = 5'(rand_bits(5));
            rs2_addr_i = 5'(rand_bits(5));
            run_cycle("redirect");
        end

        repeat (40) begin
            drive_quiet();
            reg_pc_i = rand_pc();
            run_cycle("retire exit");
        end

        repeat (RANDOM_CYCLES) begin
            drive_random_all();
            run_cycle("random");
        end
        check_all_regs("random end");

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
source/wb_pkg.sv
source/csr_pkg.sv
source/load_result_mux.sv
source/pc_redirect.sv
source/reg_file.sv
source/writeback_stage.sv
testbench/tb_writeback_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the writeback stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_writeback_stage \
    --Mdir obj_dir -o tb_writeback_stage \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_writeback_stage 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
